// ==== list.f ====
src/proc_pkg.sv
src/reg_file.sv
src/exec_unit.sv
src/op_sequencer.sv
src/proc_host_top.sv
test/tb_clock_gen.sv
test/tb_proc_host.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the processor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_proc_host -o sim_proc_host
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_proc_host)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "PASS: all tests"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== src/exec_unit.sv ====
// Purely combinational; the instruction must stay stable until the sequencer has latched the result
`default_nettype none
`timescale 1ns/1ps

module exec_unit (
    input  proc_pkg::instr_u instruction,
    output logic [3:0]       rd_addr_a,
    output logic [3:0]       rd_addr_b,
    input  logic [31:0]      rd_data_a,
    input  logic [31:0]      rd_data_b,
    output logic [31:0]      alu_value,
    output logic             sets_zero,
    output logic             wr_req,
    output logic [3:0]       wr_addr,
    output logic [31:0]      wr_data
);

    import proc_pkg::*;

    logic [31:0] imm_ext;

    // Register form addresses the two read ports
    assign rd_addr_a = instruction.reg_f.rd;
    assign rd_addr_b = instruction.reg_f.rs;

    // Immediate form feeds the LOAD path
    assign imm_ext = {14'd0, instruction.imm_f.imm};
    assign wr_addr = instruction.imm_f.rd;
    assign wr_data = imm_ext;  // Only LOAD writes the file

    always_comb begin
        alu_value = '0;  // NOP default
        sets_zero = 1'b0;
        wr_req    = 1'b0;
        case (instruction.reg_f.opcode)
            op_add: begin
                alu_value = rd_data_a + rd_data_b;  // Wraps modulo 2^32
                sets_zero = 1'b1;
            end
            op_sub: begin
                alu_value = rd_data_a - rd_data_b;
                sets_zero = 1'b1;
            end
            op_and: begin
                alu_value = rd_data_a & rd_data_b;
                sets_zero = 1'b1;
            end
            op_or: begin
                alu_value = rd_data_a | rd_data_b;
                sets_zero = 1'b1;
            end
            op_xor: begin
                alu_value = rd_data_a ^ rd_data_b;
                sets_zero = 1'b1;
            end
            op_load: begin
                alu_value = imm_ext;  // Reported and written back
                wr_req    = 1'b1;
            end
            op_store: begin
                alu_value = rd_data_a;  // Register rd as is
            end
            default: begin
                alu_value = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/op_sequencer.sv ====
// instr_valid is sampled only in idle; pulses while busy are dropped and never queued
`default_nettype none
`timescale 1ns/1ps

module op_sequencer #(
    parameter logic [31:0] pc_reset_value = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        instr_valid,
    input  logic [31:0] alu_value,
    input  logic        sets_zero,
    input  logic        wr_req,
    output logic        wr_en,
    output logic [31:0] result,
    output logic        zero_flag,
    output logic        proc_ready,
    output logic [31:0] program_counter
);

    import proc_pkg::*;

    seq_state_t state;
    logic       accept;
    logic       alu_is_zero;

    assign accept      = (state == st_idle) && instr_valid;
    assign alu_is_zero = (alu_value == '0);  // The only zero test in the design

    // One write edge per instruction
    assign wr_en = wr_req && (state == st_exec);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= st_idle;
            result          <= '0;
            zero_flag       <= 1'b0;
            proc_ready      <= 1'b0;
            program_counter <= pc_reset_value;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        proc_ready      <= 1'b0;
                        program_counter <= program_counter + pc_step;  // Once per accept
                        state           <= st_decode;
                    end
                end
                st_decode: begin
                    state <= st_exec;  // Read data settle here
                end
                st_exec: begin
                    result     <= alu_value;
                    proc_ready <= 1'b1;
                    if (sets_zero) begin
                        zero_flag <= alu_is_zero;  // Flag of the new result
                    end
                    state <= st_done;
                end
                st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Execute unit outputs are latched in exec
    a_exec_inputs_known : assert property (
        @(posedge clk) disable iff (rst)
        (state == st_exec) |-> !$isunknown({alu_value, sets_zero, wr_req})
    ) else $error("op_sequencer: unknown execute unit output at latch");

    // Ready comes back three edges after the accepting edge
    a_ready_latency : assert property (
        @(posedge clk) disable iff (rst)
        $rose(proc_ready) |-> $past(accept, 3)
    ) else $error("op_sequencer: proc_ready rose without an accept three edges before");

endmodule

`default_nettype wire

// ==== src/proc_host_top.sv ====
// One instruction in flight; hold instruction stable from accept until proc_ready rises
`default_nettype none
`timescale 1ns/1ps

module proc_host_top #(
    parameter logic [31:0] pc_reset_value = 32'h0
) (
    input  logic             clk,
    input  logic             rst,
    input  proc_pkg::instr_u instruction,
    input  logic             instr_valid,
    output logic [31:0]      result,
    output logic             zero_flag,
    output logic             proc_ready,
    output logic [31:0]      program_counter
);

    logic [3:0]  rd_addr_a;
    logic [3:0]  rd_addr_b;
    logic [31:0] rd_data_a;
    logic [31:0] rd_data_b;
    logic [31:0] alu_value;
    logic        sets_zero;
    logic        wr_req;
    logic        wr_en;   // wr_req gated by the sequencer
    logic [3:0]  wr_addr;
    logic [31:0] wr_data;

    reg_file u_reg_file (
        .clk       (clk),
        .rst       (rst),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    exec_unit u_exec_unit (
        .instruction (instruction),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .alu_value   (alu_value),
        .sets_zero   (sets_zero),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    op_sequencer #(
        .pc_reset_value (pc_reset_value)
    ) u_op_sequencer (
        .clk             (clk),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .alu_value       (alu_value),
        .sets_zero       (sets_zero),
        .wr_req          (wr_req),
        .wr_en           (wr_en),
        .result          (result),
        .zero_flag       (zero_flag),
        .proc_ready      (proc_ready),
        .program_counter (program_counter)
    );

endmodule

`default_nettype wire

// ==== src/proc_pkg.sv ====
// Opcodes sit in bits 31:26; any opcode outside 1..7 decodes as a NOP
`default_nettype none

package proc_pkg;

    // Instruction opcodes, every other value is a NOP
    typedef enum logic [5:0] {
        op_add   = 6'd1,
        op_sub   = 6'd2,
        op_and   = 6'd3,
        op_or    = 6'd4,
        op_xor   = 6'd5,
        op_load  = 6'd6,
        op_store = 6'd7
    } opcode_t;

    typedef struct packed {
        opcode_t     opcode;  // Bits 31:26
        logic [3:0]  rd;      // Destination and first source
        logic [3:0]  rs;      // Second source
        logic [17:0] unused;
    } reg_form_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [3:0]  rd;      // Load target
        logic [3:0]  unused;  // Bits 21:18, not part of the immediate
        logic [17:0] imm;     // Zero-extended on use
    } imm_form_t;

    // One instruction word, two views of it
    typedef union packed {
        reg_form_t reg_f;
        imm_form_t imm_f;
    } instr_u;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_decode = 2'd1,
        st_exec   = 2'd2,
        st_done   = 2'd3
    } seq_state_t;

    localparam logic [31:0] pc_step = 32'd4;  // Bytes per instruction

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
// Reads are combinational and a write lands on the edge where wr_en is high; no write bypass
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  rd_addr_a,
    input  logic [3:0]  rd_addr_b,
    output logic [31:0] rd_data_a,
    output logic [31:0] rd_data_b,
    input  logic        wr_en,
    input  logic [3:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [16];

    // All sixteen registers come up as zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;  // Single write port
        end
    end

    assign rd_data_a = regs[rd_addr_a];  // First source, also STORE source
    assign rd_data_b = regs[rd_addr_b];

    // The write data come from the execute unit's decode, through the sequencer's gate
    a_wr_data_known : assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown({wr_addr, wr_data})
    ) else $error("reg_file: write with unknown address or data");

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Free-running 20 ns clock; rst starts high and drops on the third rising edge
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;  // Released on an edge
    end

endmodule

`default_nettype wire

// ==== test/tb_proc_host.sv ====
// One instruction in flight at a time; results are compared at the falling edge after proc_ready rises
`default_nettype none
`timescale 1ns/1ps

module tb_proc_host;

    import proc_pkg::*;

    localparam logic [31:0] pc_base = 32'h100;
    localparam int n_nop = 57;  // Opcode 0 and 8 to 63
    localparam int planned = 2 * 16 + 200 + 1 + n_nop + 16;
    localparam int watchdog_cycles = planned * 10 + 100;

    logic        clk;
    logic        rst;
    logic [31:0] instruction;
    logic        instr_valid;
    logic [31:0] result;
    logic        zero_flag;
    logic        proc_ready;
    logic [31:0] program_counter;

    logic [31:0] model_regs [16];
    logic        model_zero;
    logic [31:0] model_pc;
    logic [31:0] pending [$];  // Accepted and not yet completed
    int          issued;
    int          done_count;
    int          errors;
    logic [31:0] cmp_word;
    logic [31:0] exp_result;
    logic        exp_zero;
    logic        exp_wr;
    logic [3:0]  exp_idx;
    logic [31:0] rnd;

    tb_clock_gen #(.reset_cycles(3)) u_clock_gen (.clk(clk), .rst(rst));

    proc_host_top #(
        .pc_reset_value (pc_base)
    ) dut0 (
        .clk             (clk),
        .rst             (rst),
        .instruction     (instruction),
        .instr_valid     (instr_valid),
        .result          (result),
        .zero_flag       (zero_flag),
        .proc_ready      (proc_ready),
        .program_counter (program_counter)
    );

    // Expected result, flag and register update from the instruction rules
    function automatic logic [31:0] predict(input logic [31:0] word,
                                            input logic [31:0] regs_in [16],
                                            input logic zero_in, output logic zero_out,
                                            output logic wr_out, output logic [3:0] wr_idx);
        logic [5:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] value;
        op       = word[31:26];
        a        = regs_in[word[25:22]];  // rd is the first source
        b        = regs_in[word[21:18]];  // rs
        value    = 32'd0;
        zero_out = zero_in;
        wr_out   = 1'b0;
        wr_idx   = word[25:22];
        case (op)
            op_add:   value = a + b;
            op_sub:   value = a - b;
            op_and:   value = a & b;
            op_or:    value = a | b;
            op_xor:   value = a ^ b;
            op_load:  value = {14'd0, word[17:0]};
            op_store: value = a;
            default:  value = 32'd0;  // NOP
        endcase
        if (op >= op_add && op <= op_xor) begin
            zero_out = (value == 32'd0);
        end
        if (op == op_load) begin
            wr_out = 1'b1;
        end
        return value;
    endfunction

    function automatic logic [31:0] make_word(input logic [5:0] op, input logic [3:0] rd,
                                              input logic [3:0] rs, input logic [17:0] low);
        return {op, rd, rs, low};
    endfunction

    // Pulse instr_valid for one accept and optionally hold it while busy
    task automatic issue_instr(input logic [31:0] word, input logic busy_pulse);
        int gap;
        gap = $urandom_range(0, 3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        instruction <= word;
        instr_valid <= 1'b1;
        @(posedge clk);  // Accepting edge
        pending.push_back(word);
        issued++;
        if (busy_pulse) begin
            repeat (3) @(posedge clk);  // Valid seen in decode, exec and done
        end
        instr_valid <= 1'b0;
        wait (done_count == issued);
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: no completion after %0d cycles", watchdog_cycles);
        errors++;
        $display("Errors: %0d", errors);
        $display("FAIL: see errors above");
        $finish;
    end

    always @(posedge proc_ready) begin
        @(negedge clk);  // Outputs settled
        if (pending.size() == 0) begin
            $display("Error at %0t: proc_ready rose with no instruction accepted", $time);
            errors++;
        end else begin
            cmp_word   = pending.pop_front();
            exp_result = predict(cmp_word, model_regs, model_zero, exp_zero, exp_wr, exp_idx);
            model_pc   = model_pc + pc_step;
            if (result !== exp_result) begin
                $display("FAILED t=%0t result expected=%h got=%h", $time, exp_result, result);
                errors++;
            end
            if (zero_flag !== exp_zero) begin
                $display("FAILED t=%0t zero_flag expected=%b got=%b", $time, exp_zero,
                         zero_flag);
                errors++;
            end
            if (program_counter !== model_pc) begin
                $display("FAILED t=%0t program_counter expected=%h got=%h", $time, model_pc,
                         program_counter);
                errors++;
            end
            if (exp_wr) begin
                model_regs[exp_idx] = exp_result;
            end
            model_zero = exp_zero;
        end
        done_count++;
    end

    initial begin
        instruction = 32'd0;
        instr_valid = 1'b0;
        issued      = 0;
        done_count  = 0;
        errors      = 0;
        model_zero  = 1'b0;
        model_pc    = pc_base;
        for (int i = 0; i < 16; i++) begin
            model_regs[i] = 32'd0;
        end
        void'($urandom(61488));

        wait (rst == 1'b0);
        repeat (2) @(negedge clk);
        if (proc_ready !== 1'b0) begin
            $display("FAILED t=%0t proc_ready expected=0 got=%b", $time, proc_ready);
            errors++;
        end
        if (zero_flag !== 1'b0) begin
            $display("FAILED t=%0t zero_flag expected=0 got=%b", $time, zero_flag);
            errors++;
        end
        if (result !== 32'd0) begin
            $display("FAILED t=%0t result expected=%h got=%h", $time, 32'd0, result);
            errors++;
        end
        if (program_counter !== pc_base) begin
            $display("FAILED t=%0t program_counter expected=%h got=%h", $time, pc_base,
                     program_counter);
            errors++;
        end

        for (int r = 0; r < 16; r++) begin
            rnd = $urandom();
            issue_instr(make_word(op_load, r[3:0], rnd[21:18], rnd[17:0]), rnd[31]);
            rnd = $urandom();
            issue_instr(make_word(op_store, r[3:0], rnd[21:18], rnd[17:0]), 1'b0);
        end

        for (int k = 0; k < 200; k++) begin
            rnd = $urandom();
            issue_instr(make_word(6'd1 + 6'($urandom_range(0, 4)), rnd[25:22], rnd[21:18],
                                  rnd[17:0]), (k == 0) || (rnd[31:30] == 2'b00));
        end
        issue_instr(make_word(op_sub, 4'd3, 4'd3, 18'd0), 1'b1);  // Self subtract sets the flag

        issue_instr(make_word(6'd0, 4'd5, 4'd6, 18'h3ffff), 1'b0);
        for (int op = 8; op < 64; op++) begin
            rnd = $urandom();
            issue_instr(make_word(op[5:0], rnd[25:22], rnd[21:18], rnd[17:0]), rnd[31]);
        end
        for (int r = 0; r < 16; r++) begin
            issue_instr(make_word(op_store, r[3:0], 4'd0, 18'd0), 1'b0);
        end

        @(negedge clk);
        if (issued != planned || done_count != planned || pending.size() != 0) begin
            $display("Error: %0d issued, %0d completed, %0d planned", issued, done_count,
                     planned);
            errors++;
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
